// File: logic/alu_pkg.sv
package alu_pkg;

  localparam int reg_w      = 64;
  localparam int imm_w      = 32;
  localparam int flags_w    = 16;
  localparam int fifo_depth = 4;
  localparam int adr_w      = 3;

  // x86 flag bit positions.
  localparam int flag_cf = 0;
  localparam int flag_pf = 2;
  localparam int flag_zf = 6;
  localparam int flag_sf = 7;
  localparam int flag_of = 11;

  localparam logic [adr_w-1:0] adr_s      = 3'd0;
  localparam logic [adr_w-1:0] adr_t      = 3'd1;
  localparam logic [adr_w-1:0] adr_cmd    = 3'd2;
  localparam logic [adr_w-1:0] adr_result = 3'd3;
  localparam logic [adr_w-1:0] adr_flags  = 3'd4;

  typedef logic [reg_w-1:0]   word_t;
  typedef logic [flags_w-1:0] flags_t;

  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_adc  = 4'd2,
    op_sbb  = 4'd3,
    op_and  = 4'd4,
    op_or   = 4'd5,
    op_xor  = 4'd6,
    op_sll  = 4'd7,
    op_mov  = 4'd8,
    op_cmp  = 4'd9,
    op_test = 4'd10
  } opcode_t;

  typedef enum logic [1:0] {w8, w16, w32, w64} width_t;

  // Command word, opcode in the low bits.
  typedef struct packed {
    logic [reg_w-imm_w-8:0] pad;
    logic [imm_w-1:0]       imm;
    logic                   use_imm;
    width_t                 width;
    opcode_t                opcode;
  } cmd_t;

  typedef struct packed {
    cmd_t  cmd;
    word_t s;
    word_t t;
  } alu_req_t;

  typedef struct packed {
    word_t  d;
    flags_t flags;
  } alu_rsp_t;

  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [adr_w-1:0] adr;
    word_t            wdata;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    word_t rdata;
  } wb_rsp_t;

  function automatic word_t mask_to_width(word_t x, width_t w);
    case (w)
      w8:      return word_t'(x[7:0]);
      w16:     return word_t'(x[15:0]);
      w32:     return word_t'(x[31:0]);
      default: return x;
    endcase
  endfunction

  function automatic logic msb_of(word_t x, width_t w);
    case (w)
      w8:      return x[7];
      w16:     return x[15];
      w32:     return x[31];
      default: return x[63];
    endcase
  endfunction

  // PF looks at the low byte only.
  function automatic logic even_parity(word_t x);
    return ~^x[7:0];
  endfunction

  function automatic flags_t make_flags(word_t r, width_t w, logic cf, logic of);
    flags_t f;
    f          = '0;
    f[flag_cf] = cf;
    f[flag_pf] = even_parity(r);
    f[flag_zf] = (r == '0);
    f[flag_sf] = msb_of(r, w);
    f[flag_of] = of;
    return f;
  endfunction

endpackage

// File: logic/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = alu_pkg::fifo_depth
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t wdata,
  input  logic     pop,
  output payload_t rdata,
  output logic     full,
  output logic     empty
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;

  assign full  = (count == (ptr_w+1)'(depth));
  assign empty = (count == '0);
  assign rdata = mem[rd_ptr];

  function automatic logic [ptr_w-1:0] next_ptr(logic [ptr_w-1:0] p);
    return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // Push and pop together leave the count alone, full or not.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: logic/alu_arith.sv
`timescale 1ns/10ps

module alu_arith (
  input  alu_pkg::opcode_t op,
  input  alu_pkg::width_t  width,
  input  alu_pkg::word_t   s,
  input  alu_pkg::word_t   t,
  input  logic             cf_in,
  output alu_pkg::word_t   d,
  output alu_pkg::flags_t  flags
);

  logic                    subtract;
  logic                    use_cf;
  logic                    cin;
  logic                    carry_out;
  logic                    carry_msb;
  alu_pkg::word_t          t_eff;
  alu_pkg::word_t          d_m;
  logic [alu_pkg::reg_w:0] sum;
  logic [alu_pkg::reg_w:0] carries;

  assign subtract = (op == alu_pkg::op_sub) || (op == alu_pkg::op_sbb) ||
                    (op == alu_pkg::op_cmp);
  assign use_cf   = (op == alu_pkg::op_adc) || (op == alu_pkg::op_sbb);

  // Subtraction is s + ~t + 1; a borrow in clears the +1.
  assign t_eff = subtract ? ~t : t;
  assign cin   = subtract ? !(use_cf && cf_in) : (use_cf && cf_in);

  assign sum     = {1'b0, s} + {1'b0, t_eff} + (alu_pkg::reg_w + 1)'(cin);
  assign carries = sum ^ {1'b0, s} ^ {1'b0, t_eff};

  // Carry into each bit; pick out the ones around the active sign bit.
  always_comb begin
    case (width)
      alu_pkg::w8:  {carry_out, carry_msb} = {carries[8], carries[7]};
      alu_pkg::w16: {carry_out, carry_msb} = {carries[16], carries[15]};
      alu_pkg::w32: {carry_out, carry_msb} = {carries[32], carries[31]};
      default:      {carry_out, carry_msb} = {carries[64], carries[63]};
    endcase
  end

  assign d_m = alu_pkg::mask_to_width(sum[alu_pkg::reg_w-1:0], width);
  assign d   = (op == alu_pkg::op_cmp) ? '0 : d_m;

  // CF is a borrow for the subtracting ops.
  assign flags = alu_pkg::make_flags(d_m, width, carry_out ^ subtract,
                                     carry_out ^ carry_msb);

endmodule

// File: logic/alu_logic.sv
`timescale 1ns/10ps

module alu_logic (
  input  alu_pkg::opcode_t op,
  input  alu_pkg::width_t  width,
  input  alu_pkg::word_t   s,
  input  alu_pkg::word_t   t,
  input  alu_pkg::flags_t  flags_in,
  output alu_pkg::word_t   d,
  output alu_pkg::flags_t  flags
);

  alu_pkg::word_t raw;
  alu_pkg::word_t r;
  logic           is_mov;

  always_comb begin
    is_mov = 1'b0;
    case (op)
      alu_pkg::op_and,
      alu_pkg::op_test: raw = s & t;
      alu_pkg::op_or:   raw = s | t;
      alu_pkg::op_xor:  raw = s ^ t;
      alu_pkg::op_sll:  raw = s << t[5:0];
      default: begin
        raw    = t;
        is_mov = 1'b1;
      end
    endcase
  end

  assign r = alu_pkg::mask_to_width(raw, width);
  assign d = (op == alu_pkg::op_test) ? '0 : r;

  // CF and OF always clear here.
  assign flags = is_mov ? flags_in : alu_pkg::make_flags(r, width, 1'b0, 1'b0);

endmodule

// File: logic/alu_exec.sv
`timescale 1ns/10ps

module alu_exec (
  input  logic              clk,
  input  logic              rst,
  input  alu_pkg::alu_req_t req_data,
  input  logic              req_empty,
  output logic              req_pop,
  output alu_pkg::alu_rsp_t rsp_data,
  input  logic              rsp_full,
  output logic              rsp_push
);

  alu_pkg::alu_req_t s1_req;
  alu_pkg::alu_req_t s1_next;
  logic              s1_valid;
  logic              s2_valid;
  logic              s1_advance;
  logic              use_arith;
  alu_pkg::word_t    arith_d;
  alu_pkg::word_t    logic_d;
  alu_pkg::flags_t   flags_q;
  alu_pkg::flags_t   flags_next;
  alu_pkg::flags_t   arith_flags;
  alu_pkg::flags_t   logic_flags;

  assign rsp_push   = s2_valid && !rsp_full;
  assign s1_advance = s1_valid && (!s2_valid || !rsp_full);
  assign req_pop    = !req_empty && (!s1_valid || s1_advance);

  // Stage 1 operand, T or the sign-extended immediate.
  always_comb begin
    s1_next = req_data;
    if (req_data.cmd.use_imm) begin
      s1_next.t = {{(alu_pkg::reg_w - alu_pkg::imm_w){req_data.cmd.imm[alu_pkg::imm_w-1]}},
                   req_data.cmd.imm};
    end
  end

  always_comb begin
    case (s1_req.cmd.opcode)
      alu_pkg::op_add, alu_pkg::op_sub, alu_pkg::op_adc,
      alu_pkg::op_sbb, alu_pkg::op_cmp: use_arith = 1'b1;
      default:                          use_arith = 1'b0;
    endcase
  end

  assign flags_next = use_arith ? arith_flags : logic_flags;

  alu_arith arith0 (
    .op    (s1_req.cmd.opcode),
    .width (s1_req.cmd.width),
    .s     (s1_req.s),
    .t     (s1_req.t),
    .cf_in (flags_q[alu_pkg::flag_cf]),
    .d     (arith_d),
    .flags (arith_flags)
  );

  alu_logic logic0 (
    .op       (s1_req.cmd.opcode),
    .width    (s1_req.cmd.width),
    .s        (s1_req.s),
    .t        (s1_req.t),
    .flags_in (flags_q),
    .d        (logic_d),
    .flags    (logic_flags)
  );

  // Flags move with the op into stage 2, so the next op sees them.
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      flags_q  <= '0;
    end else begin
      if (req_pop) begin
        s1_valid <= 1'b1;
      end else if (s1_advance) begin
        s1_valid <= 1'b0;
      end
      if (s1_advance) begin
        s2_valid <= 1'b1;
        flags_q  <= flags_next;
      end else if (rsp_push) begin
        s2_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_pop) begin
      s1_req <= s1_next;
    end
    if (s1_advance) begin
      rsp_data <= '{d: use_arith ? arith_d : logic_d, flags: flags_next};
    end
  end

endmodule

// File: logic/wb_port.sv
`timescale 1ns/10ps

module wb_port (
  input  logic               clk,
  input  logic               rst,
  input  alu_pkg::wb_req_t   bus,
  output alu_pkg::wb_rsp_t   bus_rsp,
  output logic               req_push,
  output alu_pkg::alu_req_t  req_data,
  input  logic               req_full,
  output logic               rsp_pop,
  input  alu_pkg::alu_rsp_t  rsp_data,
  input  logic               rsp_empty
);

  alu_pkg::word_t  s_q;
  alu_pkg::word_t  t_q;
  alu_pkg::word_t  rdata_q;
  alu_pkg::word_t  rdata_next;
  alu_pkg::flags_t last_flags;
  logic            ack_q;
  logic            cmd_wr;
  logic            result_rd;
  logic            ready;
  logic            accept;

  assign cmd_wr    = bus.we && (bus.adr == alu_pkg::adr_cmd);
  assign result_rd = !bus.we && (bus.adr == alu_pkg::adr_result);

  // Hold off the ack until the FIFO on the far side can take part.
  assign ready  = cmd_wr ? !req_full : (result_rd ? !rsp_empty : 1'b1);
  assign accept = bus.cyc && bus.stb && !ack_q && ready;

  always_comb begin
    rdata_next = '0;
    if (!bus.we) begin
      case (bus.adr)
        alu_pkg::adr_s:      rdata_next = s_q;
        alu_pkg::adr_t:      rdata_next = t_q;
        alu_pkg::adr_result: rdata_next = rsp_data.d;
        alu_pkg::adr_flags:  rdata_next = alu_pkg::word_t'(last_flags);
        default:             rdata_next = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q      <= 1'b0;
      req_push   <= 1'b0;
      rsp_pop    <= 1'b0;
      last_flags <= '0;
    end else begin
      ack_q    <= accept;
      req_push <= accept && cmd_wr;
      rsp_pop  <= accept && result_rd;
      if (accept && result_rd) begin
        last_flags <= rsp_data.flags;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && bus.we && bus.adr == alu_pkg::adr_s) begin
      s_q <= bus.wdata;
    end
    if (accept && bus.we && bus.adr == alu_pkg::adr_t) begin
      t_q <= bus.wdata;
    end
    if (accept && cmd_wr) begin
      req_data <= '{cmd: alu_pkg::cmd_t'(bus.wdata), s: s_q, t: t_q};
    end
    if (accept) begin
      rdata_q <= rdata_next;
    end
  end

  assign bus_rsp.ack   = ack_q;
  assign bus_rsp.rdata = rdata_q;

endmodule

// File: logic/alu_unit.sv
`timescale 1ns/10ps

module alu_unit (
  input  logic             clk,
  input  logic             rst,
  input  alu_pkg::wb_req_t bus,
  output alu_pkg::wb_rsp_t bus_rsp
);

  logic              req_push;
  logic              req_pop;
  logic              req_full;
  logic              req_empty;
  logic              rsp_push;
  logic              rsp_pop;
  logic              rsp_full;
  logic              rsp_empty;
  alu_pkg::alu_req_t req_wdata;
  alu_pkg::alu_req_t req_rdata;
  alu_pkg::alu_rsp_t rsp_wdata;
  alu_pkg::alu_rsp_t rsp_rdata;

  wb_port port0 (
    .clk       (clk),
    .rst       (rst),
    .bus       (bus),
    .bus_rsp   (bus_rsp),
    .req_push  (req_push),
    .req_data  (req_wdata),
    .req_full  (req_full),
    .rsp_pop   (rsp_pop),
    .rsp_data  (rsp_rdata),
    .rsp_empty (rsp_empty)
  );

  sync_fifo #(
    .payload_t (alu_pkg::alu_req_t),
    .depth     (alu_pkg::fifo_depth)
  ) req_fifo0 (
    .clk   (clk),
    .rst   (rst),
    .push  (req_push),
    .wdata (req_wdata),
    .pop   (req_pop),
    .rdata (req_rdata),
    .full  (req_full),
    .empty (req_empty)
  );

  alu_exec exec0 (
    .clk       (clk),
    .rst       (rst),
    .req_data  (req_rdata),
    .req_empty (req_empty),
    .req_pop   (req_pop),
    .rsp_data  (rsp_wdata),
    .rsp_full  (rsp_full),
    .rsp_push  (rsp_push)
  );

  sync_fifo #(
    .payload_t (alu_pkg::alu_rsp_t),
    .depth     (alu_pkg::fifo_depth)
  ) rsp_fifo0 (
    .clk   (clk),
    .rst   (rst),
    .push  (rsp_push),
    .wdata (rsp_wdata),
    .pop   (rsp_pop),
    .rdata (rsp_rdata),
    .full  (rsp_full),
    .empty (rsp_empty)
  );

endmodule

// File: testbench/alu_unit_asserts.sv
`timescale 1ns/10ps

module alu_unit_asserts (
  input logic             clk,
  input logic             rst,
  input alu_pkg::wb_req_t bus,
  input logic             ack,
  input logic             req_push,
  input logic             req_full
);

  int unsigned error_count = 0;

  // Ack is a single-cycle pulse.
  ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else begin
      error_count++;
      $error("ack high in two consecutive cycles");
    end

  ack_after_strobe: assert property (@(posedge clk) disable iff (rst)
                                     ack |-> $past(bus.cyc && bus.stb))
    else begin
      error_count++;
      $error("ack without a preceding cyc and stb");
    end

  push_not_full: assert property (@(posedge clk) disable iff (rst) !(req_push && req_full))
    else begin
      error_count++;
      $error("request pushed into a full FIFO");
    end

endmodule

bind wb_port alu_unit_asserts asserts0 (
  .clk      (clk),
  .rst      (rst),
  .bus      (bus),
  .ack      (bus_rsp.ack),
  .req_push (req_push),
  .req_full (req_full)
);

// File: testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int period_ns    = 8,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: testbench/tb_alu_unit.sv
`timescale 1ns/10ps

module tb_alu_unit;

  localparam int n_arith   = 200;
  localparam int n_logic   = 100;
  localparam int n_compare = 40;
  localparam int n_edge    = 24;
  localparam int n_queued  = 10;
  localparam int total_ops = 4 + n_arith + n_logic + n_compare + n_edge + n_queued;

  logic              clk;
  logic              rst;
  alu_pkg::wb_req_t  bus;
  alu_pkg::wb_rsp_t  bus_rsp;
  alu_pkg::flags_t   model_flags;
  alu_pkg::alu_rsp_t exp_q[$];
  alu_pkg::alu_rsp_t got_q[$];
  int                issued;
  int                checked;

  tb_clock_gen #(.period_ns(8), .reset_cycles(3)) clk_gen0 (.clk(clk), .rst(rst));

  alu_unit dut0 (
    .clk     (clk),
    .rst     (rst),
    .bus     (bus),
    .bus_rsp (bus_rsp)
  );

  function automatic logic signed [67:0] sign_extend(alu_pkg::word_t v, int w);
    logic signed [67:0] x;
    x = {4'b0000, v};
    if (v[w-1]) begin
      x = x - (68'sd1 <<< w);
    end
    return x;
  endfunction

  // Expected result and flags of one operation, x86 style.
  function automatic alu_pkg::alu_rsp_t ref_exec(alu_pkg::alu_req_t req, alu_pkg::flags_t fl);
    int                 w;
    alu_pkg::word_t     mask;
    alu_pkg::word_t     tv;
    alu_pkg::word_t     s_m;
    alu_pkg::word_t     t_m;
    alu_pkg::word_t     r;
    logic               cin;
    logic               cf;
    logic               keep_flags;
    logic [67:0]        wide;
    logic signed [67:0] exact;
    logic signed [67:0] lim;
    alu_pkg::alu_rsp_t  rsp;
    w    = 8 << int'(req.cmd.width);
    mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    tv   = req.cmd.use_imm ? {{32{req.cmd.imm[31]}}, req.cmd.imm} : req.t;
    s_m  = req.s & mask;
    t_m  = tv & mask;
    cin  = 1'b0;
    if (req.cmd.opcode == alu_pkg::op_adc || req.cmd.opcode == alu_pkg::op_sbb) begin
      cin = fl[alu_pkg::flag_cf];
    end
    cf         = 1'b0;
    keep_flags = 1'b0;
    exact      = '0;
    lim        = 68'sd1 <<< (w - 1);
    case (req.cmd.opcode)
      alu_pkg::op_add, alu_pkg::op_adc: begin
        wide  = {4'b0000, s_m} + {4'b0000, t_m} + 68'(cin);
        r     = wide[63:0] & mask;
        cf    = wide[w];
        exact = sign_extend(s_m, w) + sign_extend(t_m, w) + 68'(cin);
      end
      alu_pkg::op_sub, alu_pkg::op_sbb, alu_pkg::op_cmp: begin
        r     = (s_m - t_m - 64'(cin)) & mask;
        cf    = ({4'b0000, s_m} < ({4'b0000, t_m} + 68'(cin)));
        exact = sign_extend(s_m, w) - sign_extend(t_m, w) - 68'(cin);
      end
      alu_pkg::op_and, alu_pkg::op_test: r = s_m & t_m;
      alu_pkg::op_or:  r = s_m | t_m;
      alu_pkg::op_xor: r = s_m ^ t_m;
      alu_pkg::op_sll: r = (s_m << tv[5:0]) & mask;
      default: begin
        r          = t_m;
        keep_flags = 1'b1;
      end
    endcase
    if (keep_flags) begin
      rsp.flags = fl;
    end else begin
      rsp.flags                   = '0;
      rsp.flags[alu_pkg::flag_cf] = cf;
      rsp.flags[alu_pkg::flag_pf] = ~^r[7:0];
      rsp.flags[alu_pkg::flag_zf] = (r == '0);
      rsp.flags[alu_pkg::flag_sf] = r[w-1];
      rsp.flags[alu_pkg::flag_of] = (exact >= lim) || (exact < -lim);
    end
    if (req.cmd.opcode == alu_pkg::op_cmp || req.cmd.opcode == alu_pkg::op_test) begin
      rsp.d = '0;
    end else begin
      rsp.d = r;
    end
    return rsp;
  endfunction

  // Mix of edge patterns and plain random words.
  function automatic alu_pkg::word_t random_word();
    case ($urandom_range(7))
      0:       return '1;
      1:       return 64'h80 << (8 * $urandom_range(7));
      2:       return '0;
      default: return {$urandom, $urandom};
    endcase
  endfunction

  task automatic check_result(alu_pkg::word_t got, alu_pkg::word_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: result %h, expected %h", $time, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_flags(alu_pkg::flags_t got, alu_pkg::flags_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: flags %h, expected %h", $time, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "flags mismatch");
    end
  endtask

  task automatic bus_cycle(input logic we, input logic [alu_pkg::adr_w-1:0] adr,
                           input alu_pkg::word_t wdata, output alu_pkg::word_t rdata);
    alu_pkg::wb_req_t req;
    req       = '0;
    req.cyc   = 1'b1;
    req.stb   = 1'b1;
    req.we    = we;
    req.adr   = adr;
    req.wdata = wdata;
    @(posedge clk);
    bus <= req;
    @(negedge clk);
    while (!bus_rsp.ack) @(negedge clk);
    rdata = bus_rsp.rdata;
    @(posedge clk);
    bus <= '0;
  endtask

  task automatic issue_op(alu_pkg::opcode_t op, alu_pkg::width_t w, logic use_imm,
                          logic [alu_pkg::imm_w-1:0] imm, alu_pkg::word_t s, alu_pkg::word_t t);
    alu_pkg::cmd_t     cmd;
    alu_pkg::alu_req_t req;
    alu_pkg::alu_rsp_t exp;
    alu_pkg::word_t    unused;
    cmd         = '0;
    cmd.opcode  = op;
    cmd.width   = w;
    cmd.use_imm = use_imm;
    cmd.imm     = imm;
    req.cmd     = cmd;
    req.s       = s;
    req.t       = t;
    bus_cycle(1'b1, alu_pkg::adr_s, s, unused);
    bus_cycle(1'b1, alu_pkg::adr_t, t, unused);
    bus_cycle(1'b1, alu_pkg::adr_cmd, alu_pkg::word_t'(cmd), unused);
    exp         = ref_exec(req, model_flags);
    model_flags = exp.flags;
    exp_q.push_back(exp);
    issued++;
  endtask

  task automatic collect_result();
    alu_pkg::alu_rsp_t got;
    alu_pkg::word_t    data;
    bus_cycle(1'b0, alu_pkg::adr_result, '0, data);
    got.d = data;
    bus_cycle(1'b0, alu_pkg::adr_flags, '0, data);
    got.flags = data[alu_pkg::flags_w-1:0];
    got_q.push_back(got);
  endtask

  task automatic random_op(alu_pkg::opcode_t op, logic read_back);
    alu_pkg::width_t w;
    logic            use_imm;
    alu_pkg::word_t  s;
    alu_pkg::word_t  t;
    w       = alu_pkg::width_t'($urandom_range(3));
    use_imm = 1'($urandom_range(1));
    s       = random_word();
    t       = random_word();
    issue_op(op, w, use_imm, $urandom, s, t);
    if (read_back) begin
      collect_result();
    end
  endtask

  always @(posedge clk) begin : compare
    alu_pkg::alu_rsp_t got;
    alu_pkg::alu_rsp_t exp;
    if (dut0.port0.asserts0.error_count != 0) begin
      $display("A bus port assertion failed at %0t", $time);
      $display("SIMULATION FAILED");
      $fatal(1, "assertion failure");
    end
    if (got_q.size() != 0) begin
      got = got_q.pop_front();
      exp = exp_q.pop_front();
      check_result(got.d, exp.d);
      check_flags(got.flags, exp.flags);
      checked++;
    end
  end

  initial begin : watchdog
    repeat (total_ops * 200) @(posedge clk);
    $display("The simulation timed out after %0d cycles", total_ops * 200);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  end

  initial begin : stimulus
    alu_pkg::word_t data;
    alu_pkg::word_t edges[3];
    bus         = '0;
    model_flags = '0;
    issued      = 0;
    checked     = 0;
    void'($urandom(97481));
    @(negedge rst);

    bus_cycle(1'b0, alu_pkg::adr_flags, '0, data);
    check_flags(data[alu_pkg::flags_w-1:0], '0);
    bus_cycle(1'b1, alu_pkg::adr_s, 64'h0123_4567_89ab_cdef, data);
    bus_cycle(1'b0, alu_pkg::adr_s, '0, data);
    check_result(data, 64'h0123_4567_89ab_cdef);

    for (int i = 0; i < n_arith; i++) begin
      random_op(alu_pkg::opcode_t'($urandom_range(3)), 1'b1);
    end
    // AND through MOV are codes 4 to 8.
    for (int i = 0; i < n_logic; i++) begin
      random_op(alu_pkg::opcode_t'(4 + $urandom_range(4)), 1'b1);
    end
    for (int i = 0; i < n_compare; i++) begin
      random_op($urandom_range(1) ? alu_pkg::op_cmp : alu_pkg::op_test, 1'b1);
    end

    for (int wi = 0; wi < 4; wi++) begin
      edges[0] = '1;
      edges[1] = 64'd1 << ((8 << wi) - 1);
      edges[2] = '0;
      for (int e = 0; e < 3; e++) begin
        issue_op(alu_pkg::op_cmp, alu_pkg::width_t'(wi), 1'b0, '0, edges[e], edges[(e + 1) % 3]);
        collect_result();
        issue_op(alu_pkg::op_test, alu_pkg::width_t'(wi), 1'b0, '0, edges[e], edges[e]);
        collect_result();
      end
    end

    // Ten commands fill both FIFOs and both stages.
    for (int i = 0; i < n_queued; i++) begin
      random_op(alu_pkg::opcode_t'($urandom_range(10)), 1'b0);
    end
    for (int i = 0; i < n_queued; i++) begin
      collect_result();
    end

    while (checked < issued) @(posedge clk);
    if (exp_q.size() == 0 && got_q.size() == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("Results left unchecked at the end of the run");
      $display("SIMULATION FAILED");
      $fatal(1, "unchecked results");
    end
  end

endmodule

// File: project.f
logic/alu_pkg.sv
logic/sync_fifo.sv
logic/alu_arith.sv
logic/alu_logic.sv
logic/alu_exec.sv
logic/wb_port.sv
logic/alu_unit.sv
testbench/alu_unit_asserts.sv
testbench/tb_clock_gen.sv
testbench/tb_alu_unit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_alu_unit
FILELIST  ?= project.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "Run did not complete, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
